/* build.f */
src/cache_pkg.sv
src/dcache_controller.sv
src/dcache_arrays.sv
src/line_mover.sv
src/dcache_top.sv
verification/tb_clock_gen.sv
verification/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the data cache testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module dcache_tb -f build.f -o dcache_sim &&
./obj_dir/dcache_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* src/cache_pkg.sv */
package cache_pkg;

	// CPU side
	localparam int ADDR_W = 32;
	localparam int WORD_W = 64;
	localparam int BYTES_PER_WORD = WORD_W / 8;

	// line geometry
	localparam int WORDS_PER_LINE = 8;
	localparam int LINE_W = WORD_W * WORDS_PER_LINE;
	localparam int OFFSET_W = $clog2(LINE_W / 8); // byte offset in a line

	// word select sits at the top of the offset field
	localparam int WORD_LSB = $clog2(BYTES_PER_WORD);
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

	// replacement logic only handles two ways
	localparam int WAYS = 2;

	typedef logic way_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [LINE_W-1:0] line_t; // word 0 in the low bits
	typedef logic [BYTES_PER_WORD-1:0] be_t;

endpackage

/* src/dcache_arrays.sv */
`timescale 1ns/1ps

module dcache_arrays #(
	parameter int INDEX_W = 6,
	localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W
) (
	input  logic clk,
	input  logic reset,
	input  logic [INDEX_W-1:0] lookup_index,
	input  logic [cache_pkg::WORD_SEL_W-1:0] word_sel,

	input  logic word_we,
	input  cache_pkg::way_t word_way,
	input  cache_pkg::word_t word_data,
	input  cache_pkg::be_t word_be,
	input  logic fill_we,
	input  cache_pkg::way_t fill_way,
	input  logic [TAG_W-1:0] fill_tag,
	input  cache_pkg::line_t fill_line,
	input  logic touch,
	input  cache_pkg::way_t touch_way,

	output logic [TAG_W-1:0] way_tag [cache_pkg::WAYS],
	output logic way_valid [cache_pkg::WAYS],
	output logic way_dirty [cache_pkg::WAYS],
	output cache_pkg::word_t way_word [cache_pkg::WAYS],
	output cache_pkg::line_t way_line [cache_pkg::WAYS],
	output cache_pkg::way_t lru_way
);

	localparam int SETS = 1 << INDEX_W;

	logic [TAG_W-1:0] tag_mem [cache_pkg::WAYS][SETS];
	cache_pkg::word_t data_mem [cache_pkg::WAYS][SETS][cache_pkg::WORDS_PER_LINE];
	logic [SETS-1:0] valid_q [cache_pkg::WAYS];
	logic [SETS-1:0] dirty_q [cache_pkg::WAYS];
	logic [SETS-1:0] lru_q; // 1 bit per set, names the lru way

	// combinational read of the addressed set
	always_comb begin
		for (int w = 0; w < cache_pkg::WAYS; w++) begin
			way_tag[w] = tag_mem[w][lookup_index];
			way_valid[w] = valid_q[w][lookup_index];
			way_dirty[w] = dirty_q[w][lookup_index];
			way_word[w] = data_mem[w][lookup_index][word_sel];
			for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
				way_line[w][i*cache_pkg::WORD_W +: cache_pkg::WORD_W] = data_mem[w][lookup_index][i];
			end
		end
	end

	assign lru_way = lru_q[lookup_index];

	// state bits
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < cache_pkg::WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end else begin
			if (fill_we) begin
				valid_q[fill_way][lookup_index] <= 1'b1;
				dirty_q[fill_way][lookup_index] <= 1'b0;
			end
			if (word_we) begin
				dirty_q[word_way][lookup_index] <= 1'b1;
			end
			if (touch) begin
				lru_q[lookup_index] <= ~touch_way; // other way becomes lru
			end
		end
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (fill_we) begin
			tag_mem[fill_way][lookup_index] <= fill_tag;
			for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
				data_mem[fill_way][lookup_index][i] <= fill_line[i*cache_pkg::WORD_W +: cache_pkg::WORD_W];
			end
		end
		if (word_we) begin
			for (int b = 0; b < cache_pkg::BYTES_PER_WORD; b++) begin
				if (word_be[b]) begin
					data_mem[word_way][lookup_index][word_sel][b*8 +: 8] <= word_data[b*8 +: 8];
				end
			end
		end
	end

endmodule

/* src/dcache_controller.sv */
`timescale 1ns/1ps

module dcache_controller #(
	parameter int INDEX_W = 6,
	localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W
) (
	input  logic clk,
	input  logic reset,

	input  logic req_valid,
	input  logic req_write,
	input  logic [cache_pkg::ADDR_W-1:0] req_addr,
	input  cache_pkg::word_t req_wdata,
	input  cache_pkg::be_t req_be,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::word_t resp_rdata,

	output logic [INDEX_W-1:0] lookup_index,
	input  logic [TAG_W-1:0] way_tag [cache_pkg::WAYS],
	input  logic way_valid [cache_pkg::WAYS],
	input  logic way_dirty [cache_pkg::WAYS],
	input  cache_pkg::word_t way_word [cache_pkg::WAYS],
	input  cache_pkg::line_t way_line [cache_pkg::WAYS],
	input  cache_pkg::way_t lru_way,

	output logic word_we,
	output cache_pkg::way_t word_way,
	output logic [cache_pkg::WORD_SEL_W-1:0] word_sel,
	output cache_pkg::word_t word_data,
	output cache_pkg::be_t word_be,
	output logic fill_we,
	output cache_pkg::way_t fill_way,
	output logic [TAG_W-1:0] fill_tag,
	output cache_pkg::line_t fill_line,
	output logic touch,
	output cache_pkg::way_t touch_way,

	output logic move_start,
	output logic victim_dirty,
	output logic [cache_pkg::ADDR_W-1:0] victim_addr,
	output cache_pkg::line_t victim_line,
	output logic [cache_pkg::ADDR_W-1:0] fill_addr,
	input  logic move_done,
	input  cache_pkg::line_t moved_line
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOOKUP,
		S_WAIT_MOVE,
		S_RETRY
	} state_t;

	state_t state;

	// held request
	logic req_write_q;
	logic [cache_pkg::ADDR_W-1:0] req_addr_q;
	cache_pkg::word_t req_wdata_q;
	cache_pkg::be_t req_be_q;
	cache_pkg::way_t miss_way; // way being refilled

	logic [TAG_W-1:0] req_tag;
	logic hit0;
	logic hit1;
	logic hit;
	cache_pkg::way_t hit_way;
	logic in_lookup;

	assign req_tag = req_addr_q[cache_pkg::ADDR_W-1 -: TAG_W];
	assign lookup_index = req_addr_q[cache_pkg::OFFSET_W +: INDEX_W];
	assign word_sel = req_addr_q[cache_pkg::WORD_LSB +: cache_pkg::WORD_SEL_W];

	assign hit0 = way_valid[0] && (way_tag[0] == req_tag);
	assign hit1 = way_valid[1] && (way_tag[1] == req_tag);
	assign hit = hit0 || hit1;
	assign hit_way = hit1;
	assign in_lookup = (state == S_LOOKUP);

	assign req_ready = (state == S_IDLE) && !resp_valid; // low through the response cycle

	// hit service
	assign word_we = in_lookup && hit && req_write_q;
	assign word_way = hit_way;
	assign word_data = req_wdata_q;
	assign word_be = req_be_q;
	assign touch = in_lookup && hit;
	assign touch_way = hit_way;

	// refill writes in the retry cycle, moved_line is still held there
	assign fill_we = (state == S_RETRY);
	assign fill_way = miss_way;
	assign fill_tag = req_tag;
	assign fill_line = moved_line;

	// victim is whatever lru points at
	assign move_start = in_lookup && !hit;
	assign victim_dirty = way_valid[lru_way] && way_dirty[lru_way];
	assign victim_addr = {way_tag[lru_way], lookup_index, {cache_pkg::OFFSET_W{1'b0}}};
	assign victim_line = way_line[lru_way];
	assign fill_addr = {req_tag, lookup_index, {cache_pkg::OFFSET_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (req_valid && req_ready) begin
						state <= S_LOOKUP;
					end
				end
				S_LOOKUP: begin
					if (hit) begin
						resp_valid <= 1'b1;
						state <= S_IDLE;
					end else begin
						state <= S_WAIT_MOVE;
					end
				end
				S_WAIT_MOVE: begin
					if (move_done) begin
						state <= S_RETRY;
					end
				end
				S_RETRY: begin
					state <= S_LOOKUP; // request hits now
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			req_write_q <= req_write;
			req_addr_q <= req_addr;
			req_wdata_q <= req_wdata;
			req_be_q <= req_be;
		end
		if (in_lookup && hit) begin
			resp_rdata <= way_word[hit_way];
		end
		if (move_start) begin
			miss_way <= lru_way;
		end
	end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
	parameter int INDEX_W = 6
) (
	input  logic clk,
	input  logic reset,

	input  logic req_valid,
	input  logic req_write,
	input  logic [cache_pkg::ADDR_W-1:0] req_addr,
	input  cache_pkg::word_t req_wdata,
	input  cache_pkg::be_t req_be,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::word_t resp_rdata,

	output logic mem_req_valid,
	output logic mem_req_write,
	output logic [cache_pkg::ADDR_W-1:0] mem_req_addr,
	output cache_pkg::line_t mem_req_wdata,
	input  logic mem_req_ready,
	input  logic mem_resp_valid,
	input  cache_pkg::line_t mem_resp_data
);

	localparam int TAG_W = cache_pkg::ADDR_W - INDEX_W - cache_pkg::OFFSET_W;

	// controller <-> arrays
	logic [INDEX_W-1:0] lookup_index;
	logic [TAG_W-1:0] way_tag [cache_pkg::WAYS];
	logic way_valid [cache_pkg::WAYS];
	logic way_dirty [cache_pkg::WAYS];
	cache_pkg::word_t way_word [cache_pkg::WAYS];
	cache_pkg::line_t way_line [cache_pkg::WAYS];
	cache_pkg::way_t lru_way;

	logic word_we;
	cache_pkg::way_t word_way;
	logic [cache_pkg::WORD_SEL_W-1:0] word_sel;
	cache_pkg::word_t word_data;
	cache_pkg::be_t word_be;

	logic fill_we;
	cache_pkg::way_t fill_way;
	logic [TAG_W-1:0] fill_tag;
	cache_pkg::line_t fill_line;

	logic touch;
	cache_pkg::way_t touch_way;

	// controller <-> line mover
	logic move_start;
	logic victim_dirty;
	logic [cache_pkg::ADDR_W-1:0] victim_addr;
	cache_pkg::line_t victim_line;
	logic [cache_pkg::ADDR_W-1:0] fill_addr;
	logic move_done;
	cache_pkg::line_t moved_line;

	dcache_controller #(
		.INDEX_W(INDEX_W)
	) u_controller (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_be(req_be),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.lookup_index(lookup_index),
		.way_tag(way_tag),
		.way_valid(way_valid),
		.way_dirty(way_dirty),
		.way_word(way_word),
		.way_line(way_line),
		.lru_way(lru_way),
		.word_we(word_we),
		.word_way(word_way),
		.word_sel(word_sel),
		.word_data(word_data),
		.word_be(word_be),
		.fill_we(fill_we),
		.fill_way(fill_way),
		.fill_tag(fill_tag),
		.fill_line(fill_line),
		.touch(touch),
		.touch_way(touch_way),
		.move_start(move_start),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_line(victim_line),
		.fill_addr(fill_addr),
		.move_done(move_done),
		.moved_line(moved_line)
	);

	dcache_arrays #(
		.INDEX_W(INDEX_W)
	) u_arrays (
		.clk(clk),
		.reset(reset),
		.lookup_index(lookup_index),
		.word_sel(word_sel),
		.word_we(word_we),
		.word_way(word_way),
		.word_data(word_data),
		.word_be(word_be),
		.fill_we(fill_we),
		.fill_way(fill_way),
		.fill_tag(fill_tag),
		.fill_line(fill_line),
		.touch(touch),
		.touch_way(touch_way),
		.way_tag(way_tag),
		.way_valid(way_valid),
		.way_dirty(way_dirty),
		.way_word(way_word),
		.way_line(way_line),
		.lru_way(lru_way)
	);

	line_mover u_line_mover (
		.clk(clk),
		.reset(reset),
		.move_start(move_start),
		.victim_dirty(victim_dirty),
		.victim_addr(victim_addr),
		.victim_line(victim_line),
		.fill_addr(fill_addr),
		.move_done(move_done),
		.moved_line(moved_line),
		.mem_req_valid(mem_req_valid),
		.mem_req_write(mem_req_write),
		.mem_req_addr(mem_req_addr),
		.mem_req_wdata(mem_req_wdata),
		.mem_req_ready(mem_req_ready),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data)
	);

endmodule

/* src/line_mover.sv */
`timescale 1ns/1ps

module line_mover (
	input  logic clk,
	input  logic reset,

	input  logic move_start,
	input  logic victim_dirty,
	input  logic [cache_pkg::ADDR_W-1:0] victim_addr,
	input  cache_pkg::line_t victim_line,
	input  logic [cache_pkg::ADDR_W-1:0] fill_addr,
	output logic move_done,
	output cache_pkg::line_t moved_line,

	output logic mem_req_valid,
	output logic mem_req_write,
	output logic [cache_pkg::ADDR_W-1:0] mem_req_addr,
	output cache_pkg::line_t mem_req_wdata,
	input  logic mem_req_ready,
	input  logic mem_resp_valid,
	input  cache_pkg::line_t mem_resp_data
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_WRITEBACK,
		M_FILL_REQ,
		M_FILL_WAIT
	} mstate_t;

	mstate_t state;

	// latched command
	logic [cache_pkg::ADDR_W-1:0] wb_addr;
	cache_pkg::line_t wb_line;
	logic [cache_pkg::ADDR_W-1:0] rd_addr;

	// request held stable straight from state
	assign mem_req_valid = (state == M_WRITEBACK) || (state == M_FILL_REQ);
	assign mem_req_write = (state == M_WRITEBACK);
	assign mem_req_addr = (state == M_WRITEBACK) ? wb_addr : rd_addr;
	assign mem_req_wdata = wb_line;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= M_IDLE;
			move_done <= 1'b0;
		end else begin
			move_done <= 1'b0;
			case (state)
				M_IDLE: begin
					if (move_start) begin
						// clean victim skips the writeback
						state <= victim_dirty ? M_WRITEBACK : M_FILL_REQ;
					end
				end
				M_WRITEBACK: begin
					if (mem_req_ready) begin
						state <= M_FILL_REQ; // write done on accept
					end
				end
				M_FILL_REQ: begin
					if (mem_req_ready) begin
						state <= M_FILL_WAIT;
					end
				end
				M_FILL_WAIT: begin
					if (mem_resp_valid) begin
						move_done <= 1'b1;
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == M_IDLE && move_start) begin
			wb_addr <= victim_addr;
			wb_line <= victim_line;
			rd_addr <= fill_addr;
		end
		if (state == M_FILL_WAIT && mem_resp_valid) begin
			moved_line <= mem_resp_data; // held until the next fill
		end
	end

endmodule

/* verification/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

	localparam int NUM_REQUESTS = 310; // 10 directed, 300 random
	localparam int CYCLE_LIMIT = 200 * NUM_REQUESTS + 50;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_write;
	logic [cache_pkg::ADDR_W-1:0] req_addr;
	cache_pkg::word_t req_wdata;
	cache_pkg::be_t req_be;
	logic req_ready;
	logic resp_valid;
	cache_pkg::word_t resp_rdata;
	logic mem_req_valid;
	logic mem_req_write;
	logic [cache_pkg::ADDR_W-1:0] mem_req_addr;
	cache_pkg::line_t mem_req_wdata;
	logic mem_req_ready;
	logic mem_resp_valid;
	cache_pkg::line_t mem_resp_data;

	int seed = 32'hcae67885;
	int errors = 0;
	int cycle = 0;
	int issued = 0;
	int resp_count = 0;
	int accept_cycle = 0;
	int resp_cycle = 0;
	int mem_valid_cycles = 0; // cycles with mem_req_valid high
	int wb_count = 0;
	logic [cache_pkg::ADDR_W-1:0] last_wb_addr = '0;

	// outstanding expectations, one entry per request
	bit exp_is_read [$];
	cache_pkg::word_t exp_data [$];
	logic [cache_pkg::ADDR_W-1:0] exp_addr [$];

	logic [7:0] shadow [bit [31:0]]; // every byte the cpu wrote
	cache_pkg::line_t mem_lines [bit [31:0]]; // lines written back

	tb_clock_gen u_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	dcache_top #(
		.INDEX_W(6)
	) u_dcache_top (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_be(req_be),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.mem_req_valid(mem_req_valid),
		.mem_req_write(mem_req_write),
		.mem_req_addr(mem_req_addr),
		.mem_req_wdata(mem_req_wdata),
		.mem_req_ready(mem_req_ready),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data)
	);

	// untouched memory, unique per word address
	function automatic cache_pkg::word_t pattern_word(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:3], 3'b000};
		return {a ^ 32'h3c5a96e1, ~a};
	endfunction

	// written bytes over the address pattern
	function automatic cache_pkg::word_t expected_word(input logic [31:0] addr);
		logic [31:0] base;
		cache_pkg::word_t pat;
		cache_pkg::word_t r;
		int b;
		base = {addr[31:3], 3'b000};
		pat = pattern_word(base);
		for (b = 0; b < 8; b++) begin
			if (shadow.exists(base + b)) r[b*8 +: 8] = shadow[base + b];
			else r[b*8 +: 8] = pat[b*8 +: 8];
		end
		return r;
	endfunction

	function automatic cache_pkg::line_t expected_line(input logic [31:0] addr);
		cache_pkg::line_t l;
		int i;
		for (i = 0; i < 8; i++) l[i*64 +: 64] = expected_word(addr + i * 8);
		return l;
	endfunction

	function automatic cache_pkg::line_t stored_line(input logic [31:0] addr);
		cache_pkg::line_t l;
		int i;
		if (mem_lines.exists(addr)) return mem_lines[addr];
		for (i = 0; i < 8; i++) l[i*64 +: 64] = pattern_word(addr + i * 8);
		return l;
	endfunction

	task automatic check_flag(input string name, input logic want, input logic got);
		assert (got === want) else begin
			$display("FAIL %s expected %h got %h", name, want, got);
			errors++;
		end
	endtask

	task automatic issue_request(input logic write, input logic [31:0] addr,
			input cache_pkg::word_t wdata, input cache_pkg::be_t be);
		int resp_before;
		int b;
		resp_before = resp_count;
		@(posedge clk);
		#2;
		if (write) begin
			for (b = 0; b < 8; b++) begin
				if (be[b]) shadow[{addr[31:3], 3'b000} + b] = wdata[b*8 +: 8];
			end
		end
		exp_is_read.push_back(!write);
		exp_data.push_back(expected_word(addr));
		exp_addr.push_back(addr);
		issued++;
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_wdata = wdata;
		req_be = be;
		@(negedge clk);
		while (!req_ready) @(negedge clk);
		@(posedge clk); // accepted here
		#2;
		accept_cycle = cycle;
		req_valid = 1'b0;
		while (resp_count == resp_before) @(posedge clk);
	endtask

	task automatic read_word(input logic [31:0] addr);
		issue_request(1'b0, addr, '0, '0);
	endtask

	task automatic write_word(input logic [31:0] addr, input cache_pkg::word_t data,
			input cache_pkg::be_t be);
		issue_request(1'b1, addr, data, be);
	endtask

	// memory model
	initial begin
		logic [31:0] rnd;
		logic [31:0] resp_addr;
		int resp_wait;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		resp_wait = 0;
		resp_addr = '0;
		forever begin
			@(negedge clk);
			if (!reset && mem_req_valid) begin
				mem_valid_cycles++;
				if (mem_req_ready && mem_req_write) begin
					wb_count++;
					last_wb_addr = mem_req_addr;
					assert (mem_req_wdata == expected_line(mem_req_addr)) else begin
						$display("FAIL mem_req_wdata addr %h expected %h got %h",
							mem_req_addr, expected_line(mem_req_addr), mem_req_wdata);
						errors++;
					end
					mem_lines[mem_req_addr] = mem_req_wdata;
				end else if (mem_req_ready) begin
					resp_addr = mem_req_addr;
					rnd = $random(seed);
					resp_wait = 3 + int'(rnd[1:0]); // 3 to 6 cycles
				end
			end
			@(posedge clk);
			#2;
			mem_resp_valid = 1'b0;
			if (resp_wait > 0) begin
				resp_wait--;
				if (resp_wait == 0) begin
					mem_resp_valid = 1'b1;
					mem_resp_data = stored_line(resp_addr);
				end
			end
			rnd = $random(seed);
			mem_req_ready = (rnd[1:0] != 2'b00); // stalls a quarter of cycles
		end
	end

	// response compare
	always @(negedge clk) begin
		bit is_read;
		cache_pkg::word_t want;
		logic [cache_pkg::ADDR_W-1:0] a;
		if (!reset && resp_valid) begin
			resp_count++;
			resp_cycle = cycle;
			assert (exp_is_read.size() > 0) else begin
				$display("response at cycle %0d with no request outstanding", cycle);
				errors++;
			end
			if (exp_is_read.size() > 0) begin
				is_read = exp_is_read.pop_front();
				want = exp_data.pop_front();
				a = exp_addr.pop_front();
				if (is_read) begin
					assert (resp_rdata == want) else begin
						$display("FAIL resp_rdata addr %h expected %h got %h", a, want, resp_rdata);
						errors++;
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the cache stopped responding", cycle);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		int i;
		int mem_before;
		int wb_before;
		logic [31:0] r;
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] addr;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_be = '0;

		wait (reset == 1'b0);
		@(negedge clk);
		check_flag("req_ready", 1'b1, req_ready);
		check_flag("resp_valid", 1'b0, resp_valid);
		check_flag("mem_req_valid", 1'b0, mem_req_valid);

		// miss then hit in the same line
		mem_before = mem_valid_cycles;
		read_word(32'h0000_0100);
		assert (mem_valid_cycles > mem_before) else begin
			$display("read of an untouched line made no memory request");
			errors++;
		end
		mem_before = mem_valid_cycles;
		read_word(32'h0000_0108);
		assert (mem_valid_cycles == mem_before) else begin
			$display("read of a resident line went to memory");
			errors++;
		end
		assert (resp_cycle == accept_cycle + 1) else begin
			$display("hit answered %0d cycles after acceptance", resp_cycle - accept_cycle);
			errors++;
		end

		// partial byte write merges with old bytes
		write_word(32'h0000_0208, 64'h1122_3344_5566_7788, 8'b0101_1010);
		read_word(32'h0000_0208);

		// a, b, c share set 1
		read_word(32'h0001_0040);
		write_word(32'h0001_1048, 64'hdead_beef_0bad_f00d, 8'hff); // b goes dirty
		read_word(32'h0001_0040); // a touched last
		wb_before = wb_count;
		read_word(32'h0001_2040); // c evicts b
		assert (wb_count == wb_before + 1) else begin
			$display("evicting dirty line b wrote nothing back");
			errors++;
		end
		assert (last_wb_addr == 32'h0001_1040) else begin
			$display("FAIL mem_req_addr expected %h got %h", 32'h0001_1040, last_wb_addr);
			errors++;
		end
		mem_before = mem_valid_cycles;
		read_word(32'h0001_0040);
		assert (mem_valid_cycles == mem_before) else begin
			$display("line a was evicted instead of line b");
			errors++;
		end
		read_word(32'h0001_1048); // b back from memory

		// random traffic, 4 tags over 2 sets
		for (i = 0; i < 300; i++) begin
			r = $random(seed);
			d0 = $random(seed);
			d1 = $random(seed);
			addr = {18'd0, r[1:0], 5'd0, r[2], r[5:3], 3'd0};
			if (r[6]) write_word(addr, {d0, d1}, r[15:8]);
			else read_word(addr);
		end

		repeat (3) @(negedge clk);
		assert (exp_is_read.size() == 0 && resp_count == issued) else begin
			$display("%0d requests issued but %0d responses seen", issued, resp_count);
			errors++;
		end
		$display("requests %0d responses %0d errors %0d", issued, resp_count, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset = 1'b0; // released off the edge like other inputs
	end

endmodule
